/* sim.f */
+incdir+hdl
hdl/mduPkg.sv
hdl/divider.sv
hdl/multiplier.sv
hdl/hiLoFile.sv
hdl/mduTop.sv
testbench/mduTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the multiply/divide unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module mduTb \
    -o mduSim

# A failing DUT assertion may stop the run early; the search below decides
output="$(./obj_dir/mduSim 2>&1)" || true
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

/* testbench/mduTb.sv */
// Self-checking testbench for the multiply/divide unit; reference model plus concurrent checks
`default_nettype none
`timescale 1ns/1ps

`include "mdu_settings.svh"

module mduTb;

    localparam int W = `MDU_DATA_WIDTH;
    // Bound for every wait loop, in clock cycles
    localparam int waitLimit = 20;

    // Expected register contents
    typedef struct packed {
        logic [W-1:0] hi;
        logic [W-1:0] lo;
        logic         err;
    } modelStateT;

    logic           clk;
    logic           arstN;
    logic           start;
    mduPkg::mduReqT req;
    logic [W-1:0]   hi;
    logic [W-1:0]   lo;
    logic           divError;

    // Reference state and the request that produced it
    modelStateT     expState;
    mduPkg::mduReqT lastReq;

    int    errorCount;
    int    testsPassed;
    int    testsFailed;
    logic  timedOut = 1'b0;
    string timeoutWhat;

    mduTop UUT (
        .clk      (clk),
        .arstN    (arstN),
        .start    (start),
        .req      (req),
        .hi       (hi),
        .lo       (lo),
        .divError (divError)
    );

    // 8 ns clock
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Reset held for two cycles
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
    end

    // HI/LO/error after one request, straight from the instruction rules
    function automatic modelStateT nextState(modelStateT cur, mduPkg::mduReqT r);
        modelStateT  nxt;
        longint      sProd;
        logic [63:0] uProd;
        int          sa;
        int          sb;
        nxt = cur;
        nxt.err = 1'b0;
        sa = $signed(r.a);
        sb = $signed(r.b);
        case (r.op)
            mduPkg::MULT: begin
                sProd = longint'(sa) * longint'(sb);
                {nxt.hi, nxt.lo} = sProd;
            end
            mduPkg::MULTU: begin
                uProd = 64'(r.a) * 64'(r.b);
                {nxt.hi, nxt.lo} = uProd;
            end
            mduPkg::DIV: begin
                // Zero divisor or most negative over -1
                if (r.b == 0 || (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff)) begin
                    nxt.hi = '0;
                    nxt.lo = '0;
                    nxt.err = 1'b1;
                end else begin
                    // SV division truncates, remainder follows dividend
                    nxt.lo = sa / sb;
                    nxt.hi = sa % sb;
                end
            end
            mduPkg::DIVU: begin
                if (r.b == 0) begin
                    nxt.hi = '0;
                    nxt.lo = '0;
                    nxt.err = 1'b1;
                end else begin
                    nxt.lo = r.a / r.b;
                    nxt.hi = r.a % r.b;
                end
            end
            mduPkg::MTHI: nxt.hi = r.a;
            mduPkg::MTLO: nxt.lo = r.a;
            default: nxt = cur;
        endcase
        return nxt;
    endfunction

    // Model steps on the same edge as the DUT
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expState <= '0;
            lastReq  <= '0;
        end else if (start) begin
            expState <= nextState(expState, req);
            lastReq  <= req;
        end
    end

    function automatic logic isDivOp(mduPkg::mduOpE op);
        return (op == mduPkg::DIV) || (op == mduPkg::DIVU);
    endfunction

    function automatic void mismatch(string name, logic [W-1:0] expV, logic [W-1:0] actV);
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expV, actV);
        errorCount++;
    endfunction

    function automatic void failure(string what);
        $display("%0t ns %s", $time, what);
        errorCount++;
    endfunction

    // Registers one cycle after each start
    hiCheck: assert property (@(posedge clk) disable iff (!arstN)
        start |=> hi == expState.hi)
        else mismatch("hi", $sampled(expState.hi), $sampled(hi));

    loCheck: assert property (@(posedge clk) disable iff (!arstN)
        start |=> lo == expState.lo)
        else mismatch("lo", $sampled(expState.lo), $sampled(lo));

    errCheck: assert property (@(posedge clk) disable iff (!arstN)
        start |=> divError == expState.err)
        else mismatch("divError", $sampled(expState.err), $sampled(divError));

    // Quotient times divisor plus remainder, modulo the word size
    identityCheck: assert property (@(posedge clk) disable iff (!arstN)
        start && isDivOp(req.op) |=> divError || (lo * lastReq.b + hi == lastReq.a))
        else failure("Division result does not rebuild the dividend");

    holdCheck: assert property (@(posedge clk) disable iff (!arstN)
        !start |=> $stable(hi) && $stable(lo) && $stable(divError))
        else failure("HI, LO or divError changed on an idle cycle");

    // Ends the run when a wait loop gives up
    initial begin
        wait (timedOut);
        $display("Timeout while waiting for %s", timeoutWhat);
        $display("Verification failed");
        $finish;
    end

    // One request, strobe on the next rising edge
    task automatic issue(mduPkg::mduOpE opCode, logic [W-1:0] opA, logic [W-1:0] opB);
        @(posedge clk);
        start <= 1'b1;
        req   <= '{op: opCode, a: opA, b: opB};
    endtask

    task automatic idleCycles(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    // Drop start and let the last checks fire
    task automatic settle();
        int idleEdges;
        int cycles;
        idleEdges = 0;
        cycles = 0;
        @(posedge clk);
        start <= 1'b0;
        while (idleEdges < 2 && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
            if (!start) idleEdges++;
        end
        if (idleEdges < 2) begin
            timeoutWhat = "an idle request bus";
            timedOut = 1'b1;
        end
    endtask

    // X before the reset driver runs counts as still in reset
    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (arstN !== 1'b1 && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (arstN !== 1'b1) begin
            timeoutWhat = "reset release";
            timedOut = 1'b1;
        end
    endtask

    task automatic endTest(string name, int errorsAtStart);
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: FAILED with %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    initial begin
        int           errorsAtStart;
        logic [W-1:0] opA;
        logic [W-1:0] opB;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        start = 1'b0;
        req = '0;
        void'($urandom(32'h76de_14e1));

        // Registers cleared by reset
        errorsAtStart = errorCount;
        waitReset();
        @(negedge clk);
        assert (hi == '0) else mismatch("hi", '0, hi);
        assert (lo == '0) else mismatch("lo", '0, lo);
        assert (divError == 1'b0) else mismatch("divError", '0, divError);
        endTest("reset", errorsAtStart);

        errorsAtStart = errorCount;
        for (int i = 0; i < 40; i++) begin
            opA = $urandom();
            opB = $urandom();
            if (i % 2 == 0) issue(mduPkg::MULT, opA, opB);
            else issue(mduPkg::MULTU, opA, opB);
        end
        settle();
        endTest("random multiply", errorsAtStart);

        // Mixed signs first, then random with shrunken divisors
        errorsAtStart = errorCount;
        issue(mduPkg::DIV, 32'd7, -32'sd2);
        issue(mduPkg::DIV, -32'sd7, 32'd2);
        issue(mduPkg::DIV, -32'sd7, -32'sd2);
        issue(mduPkg::DIV, 32'd7, 32'd2);
        issue(mduPkg::DIV, -32'sd100, 32'd7);
        issue(mduPkg::DIV, 32'd100, -32'sd7);
        issue(mduPkg::DIVU, 32'hffff_fff9, 32'd2);
        for (int i = 0; i < 40; i++) begin
            opA = $urandom();
            opB = $urandom() >> $urandom_range(31, 0);
            if (i % 2 == 0) issue(mduPkg::DIV, opA, opB);
            else issue(mduPkg::DIVU, opA, opB);
        end
        settle();
        endTest("division", errorsAtStart);

        errorsAtStart = errorCount;
        issue(mduPkg::DIV, 32'h1234_5678, 32'd0);
        issue(mduPkg::MULT, 32'd3, 32'd5);
        issue(mduPkg::DIVU, 32'hdead_beef, 32'd0);
        issue(mduPkg::DIV, 32'h8000_0000, 32'hffff_ffff);
        // Unsigned case is an ordinary division
        issue(mduPkg::DIVU, 32'h8000_0000, 32'hffff_ffff);
        settle();
        endTest("division errors", errorsAtStart);

        errorsAtStart = errorCount;
        issue(mduPkg::MTHI, 32'h1234_5678, 32'h0);
        issue(mduPkg::MTLO, 32'h9abc_def0, 32'h0);
        idleCycles(5);
        issue(mduPkg::MTHI, 32'hcafe_0001, 32'hffff_ffff);
        idleCycles(3);
        issue(mduPkg::MTLO, 32'h0bad_f00d, 32'h0);
        settle();
        endTest("move to HI/LO and hold", errorsAtStart);

        // Consecutive strobes, no gap
        errorsAtStart = errorCount;
        issue(mduPkg::MULT, 32'hffff_fffe, 32'd9);
        issue(mduPkg::DIV, -32'sd50, 32'd6);
        issue(mduPkg::MTHI, 32'h5555_aaaa, 32'h0);
        issue(mduPkg::DIVU, 32'd77, 32'd0);
        issue(mduPkg::MTLO, 32'h0f0f_0f0f, 32'h0);
        issue(mduPkg::MULTU, 32'hffff_ffff, 32'hffff_ffff);
        issue(mduPkg::DIVU, 32'd1000, 32'd33);
        settle();
        endTest("back-to-back", errorsAtStart);

        $display("Tests passed %0d, tests failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/mduTop.sv */
// Multiply/divide unit top: request in, HI/LO and division error out, one-cycle completion
`default_nettype none
`timescale 1ns/1ps

`include "mdu_settings.svh"

module mduTop (
    input  wire                        clk,
    input  wire                        arstN,
    // One-cycle request strobe
    input  wire                        start,
    // Operation and operands, valid with start
    input  wire  mduPkg::mduReqT       req,
    output logic [`MDU_DATA_WIDTH-1:0] hi,
    output logic [`MDU_DATA_WIDTH-1:0] lo,
    // Latched by the last division
    output logic                       divError
);

    // Mode levels from the single decode in hiLoFile
    logic divSigned;
    logic mulSigned;

    // Arithmetic results
    mduPkg::mduResultT divResult;
    mduPkg::mduResultT mulResult;
    logic              divFault;

    // Remainder/quotient path
    divider uDivider (
        .a          (req.a),
        .b          (req.b),
        .signedMode (divSigned),
        .result     (divResult),
        .divError   (divFault)
    );

    // Product path, same operands
    multiplier uMultiplier (
        .a          (req.a),
        .b          (req.b),
        .signedMode (mulSigned),
        .product    (mulResult)
    );

    // Decode and registers
    hiLoFile uHiLoFile (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .req        (req),
        .divResult  (divResult),
        .divError   (divFault),
        .mulResult  (mulResult),
        .divSigned  (divSigned),
        .mulSigned  (mulSigned),
        .hi         (hi),
        .lo         (lo),
        .errorFlag  (divError)
    );

endmodule

`default_nettype wire

/* hdl/hiLoFile.sv */
// HI/LO register file: opcode decode, result selection on start, and the division error flag
`default_nettype none
`timescale 1ns/1ps

`include "mdu_settings.svh"

module hiLoFile (
    input  wire                        clk,
    input  wire                        arstN,
    // One-cycle request strobe
    input  wire                        start,
    input  wire  mduPkg::mduReqT       req,
    // Divider outputs
    input  wire  mduPkg::mduResultT    divResult,
    input  wire                        divError,
    // Multiplier output
    input  wire  mduPkg::mduResultT    mulResult,
    // Decoded mode levels back to the arithmetic blocks
    output logic                       divSigned,
    output logic                       mulSigned,
    // Register levels read by the core
    output logic [`MDU_DATA_WIDTH-1:0] hi,
    output logic [`MDU_DATA_WIDTH-1:0] lo,
    output logic                       errorFlag
);

    // Next register values
    logic [`MDU_DATA_WIDTH-1:0] hiNext;
    logic [`MDU_DATA_WIDTH-1:0] loNext;
    logic                       errorNext;

    // Division opcode seen, used by the checks
    logic isDivide;

    // Signed modes straight from the opcode
    assign divSigned = (req.op == mduPkg::DIV);
    assign mulSigned = (req.op == mduPkg::MULT);

    assign isDivide = (req.op == mduPkg::DIV) || (req.op == mduPkg::DIVU);

    // Result select
    always_comb begin
        // Hold by default
        hiNext    = hi;
        loNext    = lo;
        errorNext = errorFlag;
        if (start) begin
            case (req.op)
                mduPkg::MULT, mduPkg::MULTU: begin
                    hiNext    = mulResult.hi;
                    loNext    = mulResult.lo;
                    errorNext = 1'b0;
                end
                mduPkg::DIV, mduPkg::DIVU: begin
                    // Pair is already zero on error
                    hiNext    = divResult.hi;
                    loNext    = divResult.lo;
                    errorNext = divError;
                end
                mduPkg::MTHI: begin
                    // LO untouched
                    hiNext    = req.a;
                    errorNext = 1'b0;
                end
                mduPkg::MTLO: begin
                    // HI untouched
                    loNext    = req.a;
                    errorNext = 1'b0;
                end
                default: begin
                    // Unused codes leave everything as is
                    hiNext    = hi;
                    loNext    = lo;
                    errorNext = errorFlag;
                end
            endcase
        end
    end

    // The only state in the unit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hi        <= '0;
            lo        <= '0;
            errorFlag <= 1'b0;
        end else begin
            hi        <= hiNext;
            lo        <= loNext;
            errorFlag <= errorNext;
        end
    end

    // Core must only issue defined operations
    opKnown: assert property (@(posedge clk) disable iff (!arstN)
        start |-> !$isunknown(req.op) &&
                  (req.op inside {mduPkg::MULT, mduPkg::MULTU, mduPkg::DIV,
                                  mduPkg::DIVU, mduPkg::MTHI, mduPkg::MTLO}));

    // Faulting division leaves zeros and the flag one cycle later
    divErrorZero: assert property (@(posedge clk) disable iff (!arstN)
        start && isDivide && divError |=> (hi == '0) && (lo == '0) && errorFlag);

    // Idle cycles keep every register
    holdWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        !start |=> $stable(hi) && $stable(lo) && $stable(errorFlag));

endmodule

`default_nettype wire

/* hdl/multiplier.sv */
// Combinational 32 by 32 multiplier, signed or unsigned, giving a 64-bit HI/LO product
`default_nettype none
`timescale 1ns/1ps

`include "mdu_settings.svh"

module multiplier (
    input  wire  [`MDU_DATA_WIDTH-1:0] a,
    input  wire  [`MDU_DATA_WIDTH-1:0] b,
    // High for MULT, low for MULTU
    input  wire                        signedMode,
    // Upper half in hi, lower half in lo
    output mduPkg::mduResultT          product
);

    localparam int W = `MDU_DATA_WIDTH;

    // Operands widened to the full product width
    logic [2*W-1:0] extA;
    logic [2*W-1:0] extB;

    // Double-width product
    logic [2*W-1:0] fullProduct;

    // Sign bits used for extension
    logic fillA;
    logic fillB;

    // Zero fill in unsigned mode
    assign fillA = signedMode & a[W-1];
    assign fillB = signedMode & b[W-1];

    assign extA = {{W{fillA}}, a};
    assign extB = {{W{fillB}}, b};

    // Low 2W bits of the extended product
    // Correct for both signed and unsigned operands
    assign fullProduct = extA * extB;

    // Split into the HI/LO pair
    assign product.hi = fullProduct[2*W-1:W];
    assign product.lo = fullProduct[W-1:0];

endmodule

`default_nettype wire

/* hdl/divider.sv */
// Combinational restoring divider, signed or unsigned, remainder to HI and quotient to LO
`default_nettype none
`timescale 1ns/1ps

`include "mdu_settings.svh"

module divider (
    // Dividend
    input  wire  [`MDU_DATA_WIDTH-1:0] a,
    // Divisor
    input  wire  [`MDU_DATA_WIDTH-1:0] b,
    // High for DIV, low for DIVU
    input  wire                        signedMode,
    // Remainder in hi, quotient in lo
    output mduPkg::mduResultT          result,
    output logic                       divError
);

    localparam int W = `MDU_DATA_WIDTH;

    // Most negative two's complement value
    localparam logic [W-1:0] mostNegative = {1'b1, {(W-1){1'b0}}};

    // Operand signs, only meaningful in signed mode
    logic negA;
    logic negB;

    // Error conditions
    logic zeroDivisor;
    logic signedOverflow;

    // Unsigned magnitudes fed to the core loop
    logic [W-1:0] magA;
    logic [W-1:0] magB;

    // Core loop state
    logic [W-1:0] quotMag;
    logic [W-1:0] remMag;
    // Shifted partial remainder, one bit wider than a word
    logic [W:0]   partial;
    // Trial difference, extra top bit is the borrow
    logic [W+1:0] trial;

    // Sign-corrected results
    logic [W-1:0] quotient;
    logic [W-1:0] remainder;

    assign negA = signedMode & a[W-1];
    assign negB = signedMode & b[W-1];

    // Two's complement magnitude of negative operands
    assign magA = negA ? (~a + 1'b1) : a;
    assign magB = negB ? (~b + 1'b1) : b;

    assign zeroDivisor = (b == '0);

    // Most negative / -1 has no representable quotient in signed mode
    assign signedOverflow = signedMode && (a == mostNegative) && (b == '1);

    // Restoring shift-subtract, one quotient bit per step, MSB first
    always_comb begin
        quotMag = '0;
        remMag  = '0;
        partial = '0;
        trial   = '0;
        for (int i = W - 1; i >= 0; i--) begin
            // Bring down the next dividend bit
            partial = {remMag, magA[i]};
            // Trial subtraction of the divisor
            trial = {1'b0, partial} - {2'b00, magB};
            if (trial[W+1]) begin
                // Borrow, so restore the partial remainder
                remMag     = partial[W-1:0];
                quotMag[i] = 1'b0;
            end else begin
                // Divisor fits, keep the difference
                remMag     = trial[W-1:0];
                quotMag[i] = 1'b1;
            end
        end
    end

    // Quotient negative when operand signs differ
    assign quotient = (negA ^ negB) ? (~quotMag + 1'b1) : quotMag;

    // Remainder follows the dividend's sign
    assign remainder = negA ? (~remMag + 1'b1) : remMag;

    assign divError = zeroDivisor | signedOverflow;

    // Any error forces an all-zero pair
    assign result = divError ? '0 : mduPkg::mduResultT'{hi: remainder, lo: quotient};

endmodule

`default_nettype wire

/* hdl/mduPkg.sv */
// Shared types of the multiply/divide unit: opcode encoding, request and result words
`default_nettype none

`include "mdu_settings.svh"

package mduPkg;

    // Operations accepted on a start strobe
    // Codes 6 and 7 are unused
    typedef enum logic [`MDU_OP_WIDTH-1:0] {
        MULT  = 3'd0,
        MULTU = 3'd1,
        DIV   = 3'd2,
        DIVU  = 3'd3,
        MTHI  = 3'd4,
        MTLO  = 3'd5
    } mduOpE;

    // Request from the core
    // Only sampled while start is high
    typedef struct packed {
        mduOpE                      op;
        logic [`MDU_DATA_WIDTH-1:0] a;
        logic [`MDU_DATA_WIDTH-1:0] b;
    } mduReqT;

    // HI/LO pair
    // Product high/low half, or remainder/quotient for a division
    typedef struct packed {
        logic [`MDU_DATA_WIDTH-1:0] hi;
        logic [`MDU_DATA_WIDTH-1:0] lo;
    } mduResultT;

endpackage

`default_nettype wire

/* hdl/mdu_settings.svh */
// Width settings for the multiply/divide unit, included by the package and every RTL file
`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// Operand and HI/LO register width
`define MDU_DATA_WIDTH 32

// Opcode field width
// Six operations, so three bits
`define MDU_OP_WIDTH 3

`endif
